// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f verilog.f \
	--top-module tb_periph_top -Mdir obj_dir -o sim_periph
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_periph 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qF "All tests passed!"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

// File: verif/periph_cases.txt
# op id addr     data     strb calib resp rdata   (hex fields after op)
# op is W or R; resp 0 = okay, 2 = slverr; rdata only counts for reads
R 1 BF000000 00000000 0 0 0 00000000
R 2 BF000004 00000000 0 0 0 00000000
W 3 BF000000 00000005 F 0 0 00000000
R 4 BF000000 00000000 0 0 0 00000005
W 5 BF000000 00000002 E 0 0 00000000
R 6 BF000000 00000000 0 0 0 00000005
W 7 BF000000 FFFFFFFA 1 0 0 00000000
R 8 BF000000 00000000 0 0 0 00000002
R 9 BF000004 00000000 0 1 0 00000001
W A BF000004 FFFFFFFF F 1 0 00000000
R B BF000000 00000000 0 1 0 00000002
R C BF000004 00000000 0 0 0 00000000
W D BF001000 00000007 F 0 2 00000000
R E BF001000 00000000 0 0 2 00000000
W F 00000000 00000007 F 1 2 00000000
R 0 BEFFFFFC 00000000 0 1 2 00000000
R 1 BF000008 00000000 0 0 2 00000000
W 2 BF000FFC 00000007 F 0 2 00000000
R 3 BF000000 00000000 0 0 0 00000002
W 4 BF000000 00000007 1 1 0 00000000
R 5 BF000000 00000000 0 1 0 00000007
R 6 BF000001 00000000 0 1 2 00000000
W 7 BF000000 00000000 F 0 0 00000000
R 8 BF000000 00000000 0 0 0 00000000
W 9 BF000FFF 00000001 F 0 2 00000000
W A BF000000 00000003 1 1 0 00000000
R B BF000000 00000000 0 1 0 00000003
R C BF000004 00000000 0 1 0 00000001

// File: verif/tb_periph_top.sv
`timescale 1ns/1ps

module tb_periph_top;

	localparam logic [31:0] APB_BASE = 32'hBF00_0000;
	localparam logic [31:0] APB_END  = 32'hBF00_0FFF;
	localparam int          LED_W    = 3;

	typedef struct packed {
		logic [7:0]                    op;	// ascii W or R
		logic [periph_pkg::ID_W-1:0]   id;
		logic [periph_pkg::ADDR_W-1:0] addr;
		logic [periph_pkg::DATA_W-1:0] data;
		logic [periph_pkg::STRB_W-1:0] strb;
		logic                          calib;
		periph_pkg::axi_resp_e         resp;
		logic [periph_pkg::DATA_W-1:0] rdata;
	} case_t;

	logic                    clk = 1'b0;
	logic                    arst_n;
	periph_pkg::axi_wr_req_t wr_req;
	logic                    wr_valid;
	logic                    wr_ready;
	periph_pkg::axi_rd_req_t rd_req;
	logic                    rd_valid;
	logic                    rd_ready;
	periph_pkg::axi_b_t      b;
	logic                    b_valid;
	logic                    b_ready;
	periph_pkg::axi_r_t      r;
	logic                    r_valid;
	logic                    r_ready;
	logic                    calib_done;
	logic [LED_W:0]          led;

	case_t            cases[$];
	logic [LED_W-1:0] led_model;
	int unsigned      rand_state;
	int               cycles = 0;
	int               cycle_limit = 100;

	periph_top #(.APB_BASE(APB_BASE), .APB_END(APB_END), .LED_W(LED_W)) u_dut (.*);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit)
			abort_run($sformatf("timeout: cases not finished after %0d cycles", cycles));
	end

	function automatic int unsigned lcg_next(input int unsigned s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic in_window(input logic [31:0] addr);
		return addr >= APB_BASE && addr <= APB_END;
	endfunction

	// led register after one transaction
	function automatic logic [LED_W-1:0] led_after(input case_t c,
	                                               input logic [LED_W-1:0] cur);
		if (c.op == "W" && in_window(c.addr) && c.addr[11:0] == 12'h000 && c.strb[0])
			return c.data[LED_W-1:0];
		return cur;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "run stopped");
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("ERROR %s expected %h got %h", name, exp, act));
	endtask

	task automatic check_b(input periph_pkg::axi_b_t exp, input periph_pkg::axi_b_t act);
		if (act.id !== exp.id)
			abort_run($sformatf("ERROR b.id expected %h got %h", exp.id, act.id));
		if (act.resp !== exp.resp)
			abort_run($sformatf("ERROR b.resp expected %h got %h", exp.resp, act.resp));
	endtask

	task automatic check_r(input periph_pkg::axi_r_t exp, input periph_pkg::axi_r_t act);
		if (act.id !== exp.id)
			abort_run($sformatf("ERROR r.id expected %h got %h", exp.id, act.id));
		if (act.resp !== exp.resp)
			abort_run($sformatf("ERROR r.resp expected %h got %h", exp.resp, act.resp));
		if (act.data !== exp.data)
			abort_run($sformatf("ERROR r.data expected %h got %h", exp.data, act.data));
	endtask

	task automatic check_led(input logic [LED_W:0] exp, input logic [LED_W:0] act);
		if (act !== exp)
			abort_run($sformatf("ERROR led expected %h got %h", exp, act));
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#0.5;
	endtask

	task automatic load_cases();
		int          fd;
		int          cnt;
		string       line;
		logic [7:0]  op;
		logic [31:0] v_id, v_addr, v_data, v_strb, v_calib, v_resp, v_rdata;
		case_t       c;
		fd = $fopen("verif/periph_cases.txt", "r");
		if (fd == 0)
			abort_run("could not open the case file verif/periph_cases.txt");
		while ($fgets(line, fd) > 0) begin
			op  = 8'h00;
			cnt = $sscanf(line, "%c %h %h %h %h %h %h %h", op, v_id, v_addr, v_data,
			              v_strb, v_calib, v_resp, v_rdata);
			if (op == "W" || op == "R") begin	// comment lines skipped
				if (cnt != 8)
					abort_run($sformatf("case line has missing fields: %s", line));
				c.op    = op;
				c.id    = v_id[periph_pkg::ID_W-1:0];
				c.addr  = v_addr;
				c.data  = v_data;
				c.strb  = v_strb[periph_pkg::STRB_W-1:0];
				c.calib = v_calib[0];
				c.resp  = periph_pkg::axi_resp_e'(v_resp[1:0]);
				c.rdata = v_rdata;
				cases.push_back(c);
			end
		end
		$fclose(fd);
	endtask

	task automatic send_request(input case_t c);
		calib_done = c.calib;
		if (c.op == "W") begin
			wr_req.id   = c.id;
			wr_req.addr = c.addr;
			wr_req.data = c.data;
			wr_req.strb = c.strb;
			wr_valid    = 1'b1;
		end else begin
			rd_req.id   = c.id;
			rd_req.addr = c.addr;
			rd_valid    = 1'b1;
		end
		@(negedge clk);
		while (!(wr_valid ? wr_ready : rd_ready)) begin
			next_cycle();
			@(negedge clk);
		end
		next_cycle();	// accepted on this edge
		wr_valid = 1'b0;
		rd_valid = 1'b0;
	endtask

	task automatic take_response(input case_t c, input int delay);
		logic               is_wr;
		int                 lat;
		int                 exp_lat;
		int                 held;
		periph_pkg::axi_b_t b_exp;
		periph_pkg::axi_r_t r_exp;
		is_wr      = (c.op == "W");
		exp_lat    = in_window(c.addr) ? 3 : 1;	// setup, access, resp
		b_exp.id   = c.id;
		b_exp.resp = c.resp;
		r_exp.id   = c.id;
		r_exp.data = c.rdata;
		r_exp.resp = c.resp;
		b_ready    = is_wr & (delay == 0);
		r_ready    = ~is_wr & (delay == 0);
		lat        = 0;
		@(negedge clk);
		while (!(is_wr ? b_valid : r_valid)) begin
			if (lat >= exp_lat)
				abort_run($sformatf("no response %0d cycles after acceptance", lat));
			check_flag("wr_ready", 1'b0, wr_ready);
			next_cycle();
			lat++;
			@(negedge clk);
		end
		if (lat != exp_lat)
			abort_run($sformatf("response came %0d cycles after acceptance, not %0d",
			                    lat, exp_lat));
		if (is_wr) begin
			check_flag("r_valid", 1'b0, r_valid);
			check_b(b_exp, b);
		end else begin
			check_flag("b_valid", 1'b0, b_valid);
			check_r(r_exp, r);
		end
		for (held = 0; held < delay; held++) begin
			next_cycle();
			if (held == delay - 1) begin
				b_ready = is_wr;
				r_ready = ~is_wr;
			end
			@(negedge clk);
			check_flag("wr_ready", 1'b0, wr_ready);	// stalled in resp
			check_flag("rd_ready", 1'b0, rd_ready);
			if (is_wr) begin
				check_flag("b_valid", 1'b1, b_valid);
				check_b(b_exp, b);
			end else begin
				check_flag("r_valid", 1'b1, r_valid);
				check_r(r_exp, r);
			end
		end
		next_cycle();	// response handshake
		b_ready = 1'b0;
		r_ready = 1'b0;
		@(negedge clk);
		check_flag("b_valid", 1'b0, b_valid);
		check_flag("r_valid", 1'b0, r_valid);
		check_flag("wr_ready", 1'b1, wr_ready);
	endtask

	initial begin
		int delay;
		arst_n     = 1'b0;
		wr_req     = '0;
		wr_valid   = 1'b0;
		rd_req     = '0;
		rd_valid   = 1'b0;
		b_ready    = 1'b0;
		r_ready    = 1'b0;
		calib_done = 1'b0;
		led_model  = '0;
		rand_state = 32'd93457;
		load_cases();
		cycle_limit = 20 * cases.size() + 100;
		@(negedge clk);
		check_flag("b_valid", 1'b0, b_valid);
		check_flag("r_valid", 1'b0, r_valid);
		check_flag("wr_ready", 1'b0, wr_ready);
		check_led('0, led);
		repeat (2) @(posedge clk);
		#0.5;
		arst_n = 1'b1;
		@(negedge clk);
		check_flag("wr_ready", 1'b0, wr_ready);
		next_cycle();
		@(negedge clk);
		check_flag("wr_ready", 1'b1, wr_ready);	// idle one cycle after release
		check_flag("rd_ready", 1'b1, rd_ready);
		next_cycle();
		foreach (cases[i]) begin
			rand_state = lcg_next(rand_state);
			delay      = int'((rand_state >> 16) % 32'd4);
			send_request(cases[i]);
			take_response(cases[i], delay);
			led_model = led_after(cases[i], led_model);
			check_led({cases[i].calib, led_model}, led);
			next_cycle();
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

// File: verilog.f
verilog/periph_pkg.sv
verilog/axi_apb_bridge.sv
verilog/led_regs.sv
verilog/periph_top.sv
verif/tb_periph_top.sv

// File: verilog/axi_apb_bridge.sv
`timescale 1ns/1ps

module axi_apb_bridge #(
	parameter logic [periph_pkg::ADDR_W-1:0] APB_BASE = 32'hBF00_0000,
	parameter logic [periph_pkg::ADDR_W-1:0] APB_END  = 32'hBF00_0FFF
) (
	input  logic                    clk,
	input  logic                    arst_n,

	input  periph_pkg::axi_wr_req_t wr_req,
	input  logic                    wr_valid,
	output logic                    wr_ready,

	input  periph_pkg::axi_rd_req_t rd_req,
	input  logic                    rd_valid,
	output logic                    rd_ready,

	output periph_pkg::axi_b_t      b,
	output logic                    b_valid,
	input  logic                    b_ready,

	output periph_pkg::axi_r_t      r,
	output logic                    r_valid,
	input  logic                    r_ready,

	output periph_pkg::apb_req_t    apb_req,
	input  periph_pkg::apb_rsp_t    apb_rsp
);

	periph_pkg::bridge_state_e      state;
	logic                           ready_q;
	logic                           psel_q;
	logic                           penable_q;

	logic                           write_q;
	logic [periph_pkg::ID_W-1:0]    id_q;
	logic [periph_pkg::ADDR_W-1:0]  addr_q;
	logic [periph_pkg::DATA_W-1:0]  wdata_q;
	logic [periph_pkg::STRB_W-1:0]  strb_q;
	logic [periph_pkg::DATA_W-1:0]  rdata_q;
	periph_pkg::axi_resp_e          resp_q;

	logic                           wr_take;
	logic                           rd_take;
	logic                           in_win;
	logic                           rsp_take;
	logic                           apb_done;

	assign wr_ready = ready_q;
	assign rd_ready = ready_q & ~wr_valid;	// write wins a tie
	assign wr_take  = wr_valid & ready_q;
	assign rd_take  = rd_valid & rd_ready;

	assign in_win   = (addr_q >= APB_BASE) && (addr_q <= APB_END);
	assign apb_done = penable_q & apb_rsp.ready;
	assign rsp_take = write_q ? b_ready : r_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= periph_pkg::ST_IDLE;
			ready_q   <= 1'b0;
			psel_q    <= 1'b0;
			penable_q <= 1'b0;
		end else begin
			case (state)
				periph_pkg::ST_IDLE: begin
					ready_q <= ~(wr_take | rd_take);
					if (wr_take | rd_take)
						state <= periph_pkg::ST_SETUP;
				end
				periph_pkg::ST_SETUP: begin
					if (in_win) begin
						psel_q <= 1'b1;
						state  <= periph_pkg::ST_ACCESS;
					end else begin
						state  <= periph_pkg::ST_RESP;	// no apb cycle
					end
				end
				periph_pkg::ST_ACCESS: begin
					if (!penable_q) begin
						penable_q <= 1'b1;
					end else if (apb_rsp.ready) begin
						psel_q    <= 1'b0;
						penable_q <= 1'b0;
						state     <= periph_pkg::ST_RESP;
					end
				end
				periph_pkg::ST_RESP: begin
					if (rsp_take) begin
						state   <= periph_pkg::ST_IDLE;
						ready_q <= 1'b1;
					end
				end
				default: state <= periph_pkg::ST_IDLE;
			endcase
		end
	end

	// request and response payload
	always_ff @(posedge clk) begin
		if (wr_take) begin
			id_q    <= wr_req.id;
			addr_q  <= wr_req.addr;
			wdata_q <= wr_req.data;
			strb_q  <= wr_req.strb;
			write_q <= 1'b1;
		end else if (rd_take) begin
			id_q    <= rd_req.id;
			addr_q  <= rd_req.addr;
			wdata_q <= '0;
			strb_q  <= '0;
			write_q <= 1'b0;
		end

		if (state == periph_pkg::ST_SETUP && !in_win) begin
			resp_q  <= periph_pkg::RESP_SLVERR;
			rdata_q <= '0;
		end else if (state == periph_pkg::ST_ACCESS && apb_done) begin
			resp_q  <= apb_rsp.slverr ? periph_pkg::RESP_SLVERR : periph_pkg::RESP_OKAY;
			rdata_q <= write_q ? '0 : apb_rsp.rdata;
		end
	end

	assign apb_req.sel    = psel_q;
	assign apb_req.enable = penable_q;
	assign apb_req.write  = write_q;
	assign apb_req.addr   = addr_q;
	assign apb_req.wdata  = wdata_q;
	assign apb_req.strb   = strb_q;

	assign b_valid = (state == periph_pkg::ST_RESP) & write_q;
	assign r_valid = (state == periph_pkg::ST_RESP) & ~write_q;

	assign b.id    = id_q;
	assign b.resp  = resp_q;
	assign r.id    = id_q;
	assign r.data  = rdata_q;
	assign r.resp  = resp_q;

endmodule

// File: verilog/led_regs.sv
`timescale 1ns/1ps

module led_regs #(
	parameter int LED_W = 3
) (
	input  logic                 clk,
	input  logic                 arst_n,

	input  periph_pkg::apb_req_t apb_req,
	output periph_pkg::apb_rsp_t apb_rsp,

	input  logic                 calib_done,
	output logic [LED_W-1:0]     led_ctrl
);

	logic [LED_W-1:0] led_q;
	logic [11:0]      offset;
	logic             access;
	logic             led_wr;

	assign offset = apb_req.addr[11:0];	// window is 4K aligned
	assign access = apb_req.sel & apb_req.enable;

	// byte 0 strobe gates the led bits
	assign led_wr = access & apb_req.write & apb_req.strb[0] &
	                (offset == periph_pkg::REG_LED);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			led_q <= '0;
		else if (led_wr)
			led_q <= apb_req.wdata[LED_W-1:0];
	end

	always_comb begin
		apb_rsp.ready  = 1'b1;	// one access cycle
		apb_rsp.slverr = 1'b0;
		apb_rsp.rdata  = '0;
		if (access) begin
			case (offset)
				periph_pkg::REG_LED: begin
					apb_rsp.rdata[LED_W-1:0] = led_q;
				end
				periph_pkg::REG_STATUS: begin
					apb_rsp.rdata[0] = calib_done;	// writes dropped
				end
				default: begin
					apb_rsp.slverr = 1'b1;
				end
			endcase
		end
	end

	assign led_ctrl = led_q;

endmodule

// File: verilog/periph_pkg.sv
package periph_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = 4;
	localparam int ID_W   = 4;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'd0,
		RESP_SLVERR = 2'd2
	} axi_resp_e;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SETUP,	// decode cycle that raises psel in window
		ST_ACCESS,
		ST_RESP
	} bridge_state_e;

	// offsets inside the 4K APB window
	typedef enum logic [11:0] {
		REG_LED    = 12'h000,
		REG_STATUS = 12'h004
	} led_reg_e;

	// aw and w merged into one beat
	typedef struct packed {
		logic [ID_W-1:0]   id;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
	} axi_wr_req_t;

	typedef struct packed {
		logic [ID_W-1:0]   id;
		logic [ADDR_W-1:0] addr;
	} axi_rd_req_t;

	typedef struct packed {
		logic [ID_W-1:0] id;
		axi_resp_e       resp;
	} axi_b_t;

	typedef struct packed {
		logic [ID_W-1:0]   id;
		logic [DATA_W-1:0] data;
		axi_resp_e         resp;
	} axi_r_t;

	typedef struct packed {
		logic              sel;
		logic              enable;
		logic              write;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic [STRB_W-1:0] strb;
	} apb_req_t;

	typedef struct packed {
		logic              ready;
		logic [DATA_W-1:0] rdata;
		logic              slverr;
	} apb_rsp_t;

endpackage

// File: verilog/periph_top.sv
`timescale 1ns/1ps

module periph_top #(
	parameter logic [periph_pkg::ADDR_W-1:0] APB_BASE = 32'hBF00_0000,
	parameter logic [periph_pkg::ADDR_W-1:0] APB_END  = 32'hBF00_0FFF,
	parameter int                            LED_W    = 3
) (
	input  logic                    clk,
	input  logic                    arst_n,

	input  periph_pkg::axi_wr_req_t wr_req,
	input  logic                    wr_valid,
	output logic                    wr_ready,
	input  periph_pkg::axi_rd_req_t rd_req,
	input  logic                    rd_valid,
	output logic                    rd_ready,

	output periph_pkg::axi_b_t      b,
	output logic                    b_valid,
	input  logic                    b_ready,
	output periph_pkg::axi_r_t      r,
	output logic                    r_valid,
	input  logic                    r_ready,

	input  logic                    calib_done,
	output logic [LED_W:0]          led
);

	periph_pkg::apb_req_t apb_req;
	periph_pkg::apb_rsp_t apb_rsp;
	logic [LED_W-1:0]     led_ctrl;

	axi_apb_bridge #(
		.APB_BASE	(APB_BASE	),
		.APB_END	(APB_END	)
	) u_bridge (
		.clk		(clk		),
		.arst_n		(arst_n		),
		.wr_req		(wr_req		),
		.wr_valid	(wr_valid	),
		.wr_ready	(wr_ready	),
		.rd_req		(rd_req		),
		.rd_valid	(rd_valid	),
		.rd_ready	(rd_ready	),
		.b			(b			),
		.b_valid	(b_valid	),
		.b_ready	(b_ready	),
		.r			(r			),
		.r_valid	(r_valid	),
		.r_ready	(r_ready	),
		.apb_req	(apb_req	),
		.apb_rsp	(apb_rsp	)
	);

	led_regs #(
		.LED_W		(LED_W		)
	) u_led_regs (
		.clk		(clk		),
		.arst_n		(arst_n		),
		.apb_req	(apb_req	),
		.apb_rsp	(apb_rsp	),
		.calib_done	(calib_done	),
		.led_ctrl	(led_ctrl	)
	);

	assign led = {calib_done, led_ctrl};	// top led shows ddr calibration

endmodule
